// File: compile.f
+incdir+design
design/fetch_pkg.sv
design/icache.sv
design/bus_arbiter.sv
design/main_memory.sv
design/fetch_mem_top.sv
verification/fetch_mem_tb.sv

// File: Bender.yml
package:
  name: fetch_mem

export_include_dirs:
  - design

sources:
  # Package first, then the RTL bottom up
  - design/fetch_pkg.sv
  - design/icache.sv
  - design/bus_arbiter.sv
  - design/main_memory.sv
  - design/fetch_mem_top.sv

  - target: test
    files:
      - verification/fetch_mem_tb.sv

// File: verification/fetch_mem_tb.sv
`default_nettype none

`include "fetch_params.svh"

module fetch_mem_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLOCK_PERIOD    = 8;
    localparam int          RESET_CYCLES    = 16;
    localparam int          NUM_TESTS       = 6;
    localparam int          WATCHDOG_CYCLES = 200 * NUM_TESTS + RESET_CYCLES;
    localparam int          CACHE_LINES     = 1 << `ICACHE_INDEX_WIDTH;
    localparam int          TAG_SHIFT       = `ICACHE_OFFSET_WIDTH + `ICACHE_INDEX_WIDTH;
    localparam int          MEM_INDEX_BITS  = $clog2(`MEM_WORDS);
    localparam logic [31:0] LFSR_SEED       = 32'h7ecd_bb7d;
    localparam logic [31:0] LFSR_TAPS       = 32'hd000_0001;

    logic  clock;
    logic  reset;

    logic  ifu_arvalid;
    logic  ifu_arready;
    addr_t ifu_araddr;
    logic  ifu_rvalid;
    logic  ifu_rready;
    word_t ifu_rdata;

    logic  data_arvalid;
    logic  data_arready;
    addr_t data_araddr;
    logic  data_rvalid;
    word_t data_rdata;
    logic  data_awvalid;
    logic  data_awready;
    addr_t data_awaddr;
    word_t data_wdata;
    strb_t data_wstrb;
    logic  data_bvalid;

    // Reference models of memory and cache tags
    word_t       ref_mem    [`MEM_WORDS];
    addr_t       line_addr  [CACHE_LINES];
    logic        line_valid [CACHE_LINES];
    logic [31:0] lfsr_state = LFSR_SEED;

    fetch_mem_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] result;
        logic        out_bit;
        result = '0;
        for (int i = 0; i < count; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            result = {result[30:0], out_bit};
        end
        return result;
    endfunction

    function automatic int word_index(input addr_t addr);
        return addr[`ICACHE_OFFSET_WIDTH +: MEM_INDEX_BITS];
    endfunction

    function automatic int line_index(input addr_t addr);
        return addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    endfunction

    // Hit when the index and the upper bits match
    function automatic bit is_cached(input addr_t addr);
        int idx;
        idx = line_index(addr);
        return line_valid[idx] && ((line_addr[idx] >> TAG_SHIFT) == (addr >> TAG_SHIFT));
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    // Writes always find the bus free
    task automatic data_write(input addr_t addr, input word_t data, input strb_t strb);
        int cycles;
        int idx;
        @(posedge clock);
        data_awvalid <= 1'b1;
        data_awaddr  <= addr;
        data_wdata   <= data;
        data_wstrb   <= strb;
        @(negedge clock);
        check_value("data_awready", data_awready, 1);
        @(posedge clock);
        data_awvalid <= 1'b0;
        @(negedge clock);
        cycles = 1;
        while (!data_bvalid) begin
            @(negedge clock);
            cycles++;
        end
        check_value("data_bvalid delay", cycles, `MEM_LATENCY);
        idx = word_index(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    // Timing is only fixed when the bus is known to be free
    task automatic data_read(input addr_t addr, input bit timed);
        int cycles;
        @(posedge clock);
        data_arvalid <= 1'b1;
        data_araddr  <= addr;
        @(negedge clock);
        if (timed) begin
            check_value("data_arready", data_arready, 1);
        end
        while (!data_arready) begin
            @(negedge clock);
        end
        @(posedge clock);
        data_arvalid <= 1'b0;
        @(negedge clock);
        cycles = 1;
        while (!data_rvalid) begin
            @(negedge clock);
            cycles++;
        end
        check_value("data_rdata", data_rdata, ref_mem[word_index(addr)]);
        if (timed) begin
            check_value("data_rvalid delay", cycles, `MEM_LATENCY);
        end
    endtask

    task automatic fetch_with_stall(input addr_t addr, input int stall);
        int    cycles;
        int    idx;
        bit    expect_hit;
        word_t expected;
        word_t first;
        idx        = line_index(addr);
        expect_hit = is_cached(addr);
        expected   = ref_mem[word_index(addr)];
        @(posedge clock);
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
        ifu_rready  <= (stall == 0);
        @(negedge clock);
        while (!ifu_arready) begin
            @(negedge clock);
        end
        @(posedge clock);
        ifu_arvalid <= 1'b0;
        @(negedge clock);
        cycles = 1;
        while (!ifu_rvalid) begin
            @(negedge clock);
            cycles++;
        end
        first = ifu_rdata;
        check_value("ifu_rdata", first, expected);
        if (expect_hit) begin
            check_value("ifu_rvalid delay on hit", cycles, 1);
        end else begin
            check_value("ifu_rvalid delay on miss is long", cycles >= `MEM_LATENCY + 2, 1);
        end
        // Response must hold while ifu_rready is low
        for (int i = 0; i < stall; i++) begin
            @(negedge clock);
            check_value("ifu_rvalid held", ifu_rvalid, 1);
            check_value("ifu_rdata held", ifu_rdata, first);
        end
        if (stall > 0) begin
            @(posedge clock);
            ifu_rready <= 1'b1;
            @(negedge clock);
            check_value("ifu_rvalid at release", ifu_rvalid, 1);
            check_value("ifu_rdata at release", ifu_rdata, first);
        end
        line_valid[idx] = 1'b1;
        line_addr[idx]  = addr;
    endtask

    task automatic fetch(input addr_t addr);
        fetch_with_stall(addr, 0);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic check_reset_state();
        addr_t addr;
        @(negedge clock);
        check_value("ifu_rvalid", ifu_rvalid, 0);
        check_value("data_rvalid", data_rvalid, 0);
        check_value("data_bvalid", data_bvalid, 0);
        check_value("ifu_arready", ifu_arready, 1);
        for (int i = 0; i < 4; i++) begin
            addr      = random_bits(32);
            addr[1:0] = 2'b00;
            data_read(addr, 1'b1);
        end
    endtask

    task automatic write_read_merge();
        addr_t addr;
        word_t data;
        strb_t strb;
        for (int i = 0; i < 8; i++) begin
            addr = 32'h40 + 8 * i;
            data = random_bits(32);
            data_write(addr, data, 4'hf);
        end
        // Partial overwrites merge into the full words
        for (int i = 0; i < 8; i++) begin
            addr = 32'h40 + 8 * i;
            data = random_bits(32);
            strb = random_bits(4);
            data_write(addr, data, strb);
        end
        for (int i = 0; i < 8; i++) begin
            data_read(32'h40 + 8 * i, 1'b1);
        end
    endtask

    task automatic fetch_hit_after_miss();
        fetch(32'h48);
        fetch(32'h48);
        fetch(32'h58);
        fetch(32'h58);
    endtask

    // Index 0 with two different tags
    task automatic fetch_index_conflict();
        for (int i = 0; i < 2; i++) begin
            fetch(32'h40);
            fetch(32'h60);
        end
    endtask

    task automatic fetch_with_data_read();
        addr_t fetch_addr [3] = '{32'h70, 32'h78, 32'h50};
        addr_t read_addr  [3] = '{32'h58, 32'h68, 32'h60};
        for (int d = 0; d < 3; d++) begin
            fork
                fetch(fetch_addr[d]);
                begin
                    // d of 2 meets the refill request in the same cycle
                    repeat (d) @(posedge clock);
                    data_read(read_addr[d], 1'b0);
                end
            join
        end
    endtask

    task automatic stalled_responses();
        fetch_with_stall(32'h78, 4);
        fetch_with_stall(32'h68, 5);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        reset        = 1'b1;
        ifu_arvalid  = 1'b0;
        ifu_araddr   = '0;
        ifu_rready   = 1'b1;
        data_arvalid = 1'b0;
        data_araddr  = '0;
        data_awvalid = 1'b0;
        data_awaddr  = '0;
        data_wdata   = '0;
        data_wstrb   = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < CACHE_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_addr[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        check_reset_state();
        write_read_merge();
        fetch_hit_after_miss();
        fetch_index_conflict();
        fetch_with_data_read();
        stalled_responses();

        repeat (2) @(posedge clock);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/fetch_mem_top.sv
`default_nettype none

module fetch_mem_top
    import fetch_pkg::*;
(
    input  wire         clock,
    input  wire         reset,

    // --------------------
    // Fetch port
    // --------------------
    input  wire         ifu_arvalid,
    output logic        ifu_arready,
    input  wire  addr_t ifu_araddr,
    output logic        ifu_rvalid,
    input  wire         ifu_rready,
    output word_t       ifu_rdata,

    // --------------------
    // Data port
    // --------------------
    input  wire         data_arvalid,
    output logic        data_arready,
    input  wire  addr_t data_araddr,
    output logic        data_rvalid,
    output word_t       data_rdata,
    input  wire         data_awvalid,
    output logic        data_awready,
    input  wire  addr_t data_awaddr,
    input  wire  word_t data_wdata,
    input  wire  strb_t data_wstrb,
    output logic        data_bvalid
);

    // Refill bus, cache to arbiter
    logic  cache_arvalid;
    logic  cache_arready;
    addr_t cache_araddr;
    logic  cache_rvalid;
    word_t cache_rdata;

    // Shared memory bus
    logic  mem_arvalid;
    logic  mem_arready;
    addr_t mem_araddr;
    logic  mem_awvalid;
    logic  mem_awready;
    addr_t mem_awaddr;
    word_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_rvalid;
    word_t mem_rdata;
    logic  mem_bvalid;

    // Port names match the nets above one to one
    icache icache_i (.*);

    bus_arbiter bus_arbiter_i (.*);

    main_memory main_memory_i (.*);

endmodule

`default_nettype wire

// File: design/main_memory.sv
`default_nettype none

`include "fetch_params.svh"

module main_memory
    import fetch_pkg::*;
(
    input  wire         clock,
    input  wire         reset,

    input  wire         mem_arvalid,
    output logic        mem_arready,
    input  wire  addr_t mem_araddr,

    input  wire         mem_awvalid,
    output logic        mem_awready,
    input  wire  addr_t mem_awaddr,
    input  wire  word_t mem_wdata,
    input  wire  strb_t mem_wstrb,

    output logic        mem_rvalid,
    output word_t       mem_rdata,
    output logic        mem_bvalid
);

    localparam int WORD_BITS = $clog2(`MEM_WORDS);
    localparam int CNT_BITS  = $clog2(`MEM_LATENCY) + 1;

    mem_state_t           state;
    logic [CNT_BITS-1:0]  count;
    logic                 is_write;
    logic                 rd_fire;
    logic                 wr_fire;
    logic [WORD_BITS-1:0] rd_index;
    logic [WORD_BITS-1:0] wr_index;

    word_t                mem [`MEM_WORDS];

    // Write wins if both show up together
    assign mem_awready = (state == MEM_IDLE);
    assign mem_arready = (state == MEM_IDLE) && !mem_awvalid;

    assign rd_fire = mem_arvalid && mem_arready;
    assign wr_fire = mem_awvalid && mem_awready;

    // Word bits only, upper address bits ignored
    assign rd_index = mem_araddr[`ICACHE_OFFSET_WIDTH +: WORD_BITS];
    assign wr_index = mem_awaddr[`ICACHE_OFFSET_WIDTH +: WORD_BITS];

    assign mem_rvalid = (state == MEM_RESPOND) && !is_write;
    assign mem_bvalid = (state == MEM_RESPOND) && is_write;

    // --------------------
    // Latency sequencing
    // --------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= MEM_IDLE;
            count    <= '0;
            is_write <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (rd_fire || wr_fire) begin
                        state    <= MEM_BUSY;
                        // Busy lasts latency minus one cycles
                        count    <= CNT_BITS'(`MEM_LATENCY - 2);
                        is_write <= wr_fire;
                    end
                end
                MEM_BUSY: begin
                    if (count == '0) begin
                        state <= MEM_RESPOND;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= MEM_IDLE;
                end
            endcase
        end
    end

    // Read word taken at acceptance
    always_ff @(posedge clock) begin
        if (rd_fire) begin
            mem_rdata <= mem[rd_index];
        end
    end

    // Storage with byte enables
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < `FETCH_DATA_WIDTH / 8; b++) begin
                if (mem_wstrb[b]) begin
                    mem[wr_index][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
`default_nettype none

module bus_arbiter
    import fetch_pkg::*;
(
    input  wire         clock,
    input  wire         reset,

    // Master 0, cache refill
    input  wire         cache_arvalid,
    output logic        cache_arready,
    input  wire  addr_t cache_araddr,
    output logic        cache_rvalid,
    output word_t       cache_rdata,

    // Master 1, data port
    input  wire         data_arvalid,
    output logic        data_arready,
    input  wire  addr_t data_araddr,
    output logic        data_rvalid,
    output word_t       data_rdata,
    input  wire         data_awvalid,
    output logic        data_awready,
    input  wire  addr_t data_awaddr,
    input  wire  word_t data_wdata,
    input  wire  strb_t data_wstrb,
    output logic        data_bvalid,

    // Shared memory bus
    output logic        mem_arvalid,
    input  wire         mem_arready,
    output addr_t       mem_araddr,
    output logic        mem_awvalid,
    input  wire         mem_awready,
    output addr_t       mem_awaddr,
    output word_t       mem_wdata,
    output strb_t       mem_wstrb,
    input  wire         mem_rvalid,
    input  wire  word_t mem_rdata,
    input  wire         mem_bvalid
);

    arb_owner_t owner;
    logic       last_data;
    logic       data_req;
    logic       pick_data;
    logic       accepted;

    assign data_req = data_arvalid || data_awvalid;

    // On a tie, serve whoever lost last time
    assign pick_data = data_req && (!cache_arvalid || !last_data);

    assign accepted = (mem_arvalid && mem_arready) || (mem_awvalid && mem_awready);

    // --------------------
    // Request forwarding
    // --------------------
    always_comb begin
        mem_arvalid   = 1'b0;
        mem_awvalid   = 1'b0;
        cache_arready = 1'b0;
        data_arready  = 1'b0;
        data_awready  = 1'b0;
        if (owner == ARB_NONE) begin
            if (pick_data) begin
                // Write goes first when the data port asks for both
                if (data_awvalid) begin
                    mem_awvalid  = 1'b1;
                    data_awready = mem_awready;
                end else begin
                    mem_arvalid  = 1'b1;
                    data_arready = mem_arready;
                end
            end else if (cache_arvalid) begin
                mem_arvalid   = 1'b1;
                cache_arready = mem_arready;
            end
        end
    end

    assign mem_araddr = pick_data ? data_araddr : cache_araddr;

    // Only the data port writes
    assign mem_awaddr = data_awaddr;
    assign mem_wdata  = data_wdata;
    assign mem_wstrb  = data_wstrb;

    // --------------------
    // Response steering
    // --------------------
    assign cache_rvalid = (owner == ARB_FETCH) && mem_rvalid;
    assign cache_rdata  = mem_rdata;
    assign data_rvalid  = (owner == ARB_DATA) && mem_rvalid;
    assign data_rdata   = mem_rdata;
    assign data_bvalid  = (owner == ARB_DATA) && mem_bvalid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner     <= ARB_NONE;
            last_data <= 1'b0;
        end else begin
            case (owner)
                ARB_NONE: begin
                    if (accepted) begin
                        owner     <= pick_data ? ARB_DATA : ARB_FETCH;
                        last_data <= pick_data;
                    end
                end
                default: begin
                    // Bus frees up on the response pulse
                    if (mem_rvalid || mem_bvalid) begin
                        owner <= ARB_NONE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/icache.sv
`default_nettype none

`include "fetch_params.svh"

module icache
    import fetch_pkg::*;
(
    input  wire         clock,
    input  wire         reset,

    // Fetch request
    input  wire         ifu_arvalid,
    output logic        ifu_arready,
    input  wire  addr_t ifu_araddr,

    // Fetch response, the only one with back-pressure
    output logic        ifu_rvalid,
    input  wire         ifu_rready,
    output word_t       ifu_rdata,

    // Refill bus toward the arbiter
    output logic        cache_arvalid,
    input  wire         cache_arready,
    output addr_t       cache_araddr,
    input  wire         cache_rvalid,
    input  wire  word_t cache_rdata
);

    localparam int ENTRIES = 1 << `ICACHE_INDEX_WIDTH;
    localparam int TAG_LSB = `ICACHE_OFFSET_WIDTH + `ICACHE_INDEX_WIDTH;

    icache_state_t      state;
    icache_state_t      state_next;
    addr_t              addr_q;
    index_t             index;
    tag_t               tag;
    logic               hit;
    logic               fill;

    // Entry storage
    word_t              data_mem [ENTRIES];
    tag_t               tag_mem  [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    // --------------------
    // Lookup
    // --------------------
    assign index = addr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
    assign tag   = addr_q[`FETCH_ADDR_WIDTH-1:TAG_LSB];
    assign hit   = valid_q[index] && (tag_mem[index] == tag);

    // Refill word arrives
    assign fill = (state == IC_MISS_WAIT) && cache_rvalid;

    assign ifu_arready   = (state == IC_IDLE);
    assign cache_arvalid = (state == IC_MISS_REQ);
    assign cache_araddr  = addr_q;

    // Forward the refill word directly, otherwise read the array
    assign ifu_rdata = fill ? cache_rdata : data_mem[index];

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        ifu_rvalid = 1'b0;
        state_next = state;
        case (state)
            IC_IDLE: begin
                if (ifu_arvalid) begin
                    state_next = IC_LOOKUP;
                end
            end
            IC_LOOKUP: begin
                if (hit) begin
                    ifu_rvalid = 1'b1;
                    state_next = ifu_rready ? IC_IDLE : IC_HIT_HOLD;
                end else begin
                    state_next = IC_MISS_REQ;
                end
            end
            IC_MISS_REQ: begin
                if (cache_arready) begin
                    state_next = IC_MISS_WAIT;
                end
            end
            IC_MISS_WAIT: begin
                if (cache_rvalid) begin
                    ifu_rvalid = 1'b1;
                    state_next = ifu_rready ? IC_IDLE : IC_MISS_HOLD;
                end
            end
            // Both hold states replay the entry that is now in the array
            IC_HIT_HOLD,
            IC_MISS_HOLD: begin
                ifu_rvalid = 1'b1;
                if (ifu_rready) begin
                    state_next = IC_IDLE;
                end
            end
            default: begin
                state_next = IC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= IC_IDLE;
            valid_q <= '0;
        end else begin
            state <= state_next;
            if (fill) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // Address latch and entry write
    always_ff @(posedge clock) begin
        if (ifu_arvalid && ifu_arready) begin
            addr_q <= ifu_araddr;
        end
        if (fill) begin
            data_mem[index] <= cache_rdata;
            tag_mem[index]  <= tag;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

    // Vectors with a meaning on the bus
    typedef logic [`FETCH_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`FETCH_DATA_WIDTH-1:0] word_t;
    typedef logic [`FETCH_DATA_WIDTH/8-1:0] strb_t;

    // Cache address fields
    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [`FETCH_ADDR_WIDTH-`ICACHE_INDEX_WIDTH-`ICACHE_OFFSET_WIDTH-1:0] tag_t;

    // --------------------
    // State machines
    // --------------------
    typedef enum logic [2:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_HIT_HOLD,
        IC_MISS_REQ,
        IC_MISS_WAIT,
        IC_MISS_HOLD
    } icache_state_t;

    typedef enum logic [1:0] {
        ARB_NONE,
        ARB_FETCH,
        ARB_DATA
    } arb_owner_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_BUSY,
        MEM_RESPOND
    } mem_state_t;

endpackage

`default_nettype wire

// File: design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// --------------------
// Bus widths
// --------------------
`define FETCH_ADDR_WIDTH 32
`define FETCH_DATA_WIDTH 32

// --------------------
// Cache geometry
// --------------------
// Byte offset within a word
`define ICACHE_OFFSET_WIDTH 2
// Eight direct-mapped entries
`define ICACHE_INDEX_WIDTH 3

// --------------------
// Backing memory
// --------------------
`define MEM_WORDS 256
// Cycles from accepted request to response pulse
`define MEM_LATENCY 3

`endif
